/* logic/cart_mem_pkg.sv */
`default_nettype none

package cart_mem_pkg;

  // ----------------------------------------------------------------------
  // bus widths
  // ----------------------------------------------------------------------
  localparam int ADDR_W = 24;  // mcu and console byte address
  localparam int DATA_W = 8;
  localparam int ROM_AW = 23;  // psram word address
  localparam int RAM_AW = 19;  // 512KB sram

  // ----------------------------------------------------------------------
  // address regions
  // ----------------------------------------------------------------------
  // 880000-8FFFFF goes to the sram holding the console rom image
  localparam logic [4:0] RAM_REGION = 5'b10001;

  // ----------------------------------------------------------------------
  // psram data word
  // ----------------------------------------------------------------------
  // even byte address sits in hi, odd in lo
  typedef union packed {
    logic [15:0] word;
    struct packed {
      logic [DATA_W-1:0] hi;
      logic [DATA_W-1:0] lo;
    } lanes;
  } psram_data_t;

endpackage

`default_nettype wire

/* logic/snes_bus_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module snes_bus_sync #(
  parameter int unsigned DEAD_TIMEOUT = 84000
) (
  input  logic                            CLK2,
  input  logic                            rst_n,
  input  logic [cart_mem_pkg::ADDR_W-1:0] snes_addr_in,
  input  logic                            snes_read_in,
  input  logic                            snes_romsel_in,
  input  logic                            snes_cpu_clk_in,
  output logic [cart_mem_pkg::ADDR_W-1:0] snes_addr,
  output logic                            snes_read,
  output logic                            snes_romsel,
  output logic                            cycle_start,
  output logic                            cycle_end,
  output logic                            snes_dead,
  output logic                            snes_revive
);
  import cart_mem_pkg::*;

  localparam int CNT_W = $clog2(DEAD_TIMEOUT + 2);

  logic [2:0]        read_r;
  logic [5:0]        romsel_r;
  logic [6:0]        cpu_clk_r;
  logic [ADDR_W-1:0] addr_r [7];
  logic [CNT_W-1:0]  dead_cnt;

  // ----------------------------------------------------------------------
  // sample shift registers
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      read_r    <= '1;  // bus idle: no read, no rom select
      romsel_r  <= '1;
      cpu_clk_r <= '0;
    end else begin
      read_r    <= {read_r[1:0], snes_read_in};
      romsel_r  <= {romsel_r[4:0], snes_romsel_in};
      cpu_clk_r <= {cpu_clk_r[5:0], snes_cpu_clk_in};
    end
  end

  always_ff @(posedge CLK2) begin
    addr_r[0] <= snes_addr_in;
    for (int i = 1; i < 7; i++) begin
      addr_r[i] <= addr_r[i-1];
    end
  end

  // two aged samples ANDed to drop single-cycle glitches
  assign snes_addr   = addr_r[6] & addr_r[5];
  assign snes_read   = read_r[2] & read_r[1];
  assign snes_romsel = romsel_r[5] & romsel_r[4];

  assign cycle_start = (cpu_clk_r[6:1] == 6'b000001);  // rising edge
  assign cycle_end   = (cpu_clk_r[6:1] == 6'b111110);  // falling edge

  // ----------------------------------------------------------------------
  // dead console detection
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      dead_cnt  <= '0;
      snes_dead <= 1'b1;  // no console until a clock is seen
    end else if (cpu_clk_r[1]) begin
      dead_cnt  <= '0;
      snes_dead <= 1'b0;
    end else begin
      if (dead_cnt <= CNT_W'(DEAD_TIMEOUT)) dead_cnt <= dead_cnt + 1'b1;  // stops past timeout
      if (dead_cnt > CNT_W'(DEAD_TIMEOUT)) snes_dead <= 1'b1;
    end
  end

  // first clock-high sample after a dead period
  assign snes_revive = snes_dead & cpu_clk_r[1];

endmodule

`default_nettype wire

/* logic/snes_rom_map.sv */
`timescale 1ns/1ps
`default_nettype none

module snes_rom_map (
  input  logic                            CLK2,
  input  logic                            rst_n,
  input  logic [cart_mem_pkg::ADDR_W-1:0] snes_addr,
  input  logic                            snes_romsel,
  input  logic                            cycle_start,
  input  logic                            cycle_end,
  input  logic                            snes_dead,
  output logic                            rom_hit,
  output logic [cart_mem_pkg::RAM_AW-1:0] snes_ram_addr,
  output logic                            access_window
);

  logic idle_strobe;

  assign rom_hit = ~snes_romsel;

  // lorom style: bank bits 19..16, drop A15
  assign snes_ram_addr = {snes_addr[19:16], snes_addr[14:0]};

  // console cycle that does not touch the rom leaves the sram free
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      idle_strobe <= 1'b0;
    end else begin
      idle_strobe <= cycle_start & ~rom_hit;
    end
  end

  assign access_window = cycle_end | idle_strobe | snes_dead;

endmodule

`default_nettype wire

/* logic/mem_access_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_access_seq #(
  parameter int unsigned CYCLE_LEN = 7,
  parameter int unsigned ADDR_W_P  = 24
) (
  input  logic                CLK2,
  input  logic                rst_n,
  input  logic                rrq,
  input  logic                wrq,
  input  logic [ADDR_W_P-1:0] req_addr_in,
  input  logic                access_window,
  input  logic                abort,
  output logic                rdy,
  output logic [ADDR_W_P-1:0] req_addr,
  output logic                rd_phase,
  output logic                wr_phase,
  output logic                wr_busy,
  output logic                rd_done
);

  localparam int DLY_W = (CYCLE_LEN > 0) ? $clog2(CYCLE_LEN + 1) : 1;

  localparam logic [2:0] ST_IDLE = 3'b001;
  localparam logic [2:0] ST_ADDR = 3'b010;
  localparam logic [2:0] ST_END  = 3'b100;

  logic [2:0]       state;
  logic [DLY_W-1:0] delay;
  logic             rd_pend;
  logic             wr_pend;

  // ----------------------------------------------------------------------
  // request bookkeeping
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      rdy     <= 1'b1;
    end else if (rrq) begin
      rd_pend <= 1'b1;
      rdy     <= 1'b0;
    end else if (wrq) begin
      wr_pend <= 1'b1;
      rdy     <= 1'b0;
    end else if (state == ST_END) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      rdy     <= 1'b1;  // one cycle after the end state
    end
  end

  always_ff @(posedge CLK2) begin
    if (rrq | wrq) req_addr <= req_addr_in;
  end

  // ----------------------------------------------------------------------
  // access sequence
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      delay <= '0;
    end else if (abort) begin
      state <= ST_IDLE;  // pend flags kept, access reruns
    end else begin
      case (state)
        ST_IDLE: begin
          if ((rd_pend | wr_pend) & access_window) begin
            state <= ST_ADDR;
            delay <= DLY_W'(CYCLE_LEN);
          end
        end
        ST_ADDR: begin
          delay <= delay - 1'b1;
          if (delay == '0) state <= ST_END;  // CYCLE_LEN+1 cycles here
        end
        ST_END: state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign rd_phase = (state == ST_ADDR) & rd_pend;
  assign wr_phase = (state == ST_ADDR) & wr_pend;
  assign wr_busy  = ((state == ST_ADDR) | (state == ST_END)) & wr_pend;
  assign rd_done  = (state == ST_END) & rd_pend;

endmodule

`default_nettype wire

/* logic/psram_port.sv */
`timescale 1ns/1ps
`default_nettype none

module psram_port #(
  parameter int unsigned ROM_CYCLE_LEN = 7
) (
  input  logic                            CLK2,
  input  logic                            rst_n,
  input  logic                            mcu_rrq_rom,
  input  logic                            mcu_wrq_rom,
  input  logic [cart_mem_pkg::ADDR_W-1:0] mcu_addr,
  input  logic [cart_mem_pkg::DATA_W-1:0] mcu_dout,
  input  logic                            access_window,
  input  logic                            snes_revive,
  output logic                            rdy,
  output logic                            rd_done,
  output logic [cart_mem_pkg::DATA_W-1:0] rd_byte,
  output logic [cart_mem_pkg::ROM_AW-1:0] rom_addr,
  output logic                            rom_we,
  output logic                            rom_bhe,
  output logic                            rom_ble,
  inout  wire  [15:0]                     rom_data
);
  import cart_mem_pkg::*;

  logic [ADDR_W-1:0] req_addr;
  logic              rd_phase;
  logic              wr_phase;
  logic              wr_busy;
  logic              odd;
  psram_data_t       rom_rd;

  mem_access_seq #(
    .CYCLE_LEN (ROM_CYCLE_LEN),
    .ADDR_W_P  (ADDR_W)
  ) u_seq (
    .CLK2          (CLK2),
    .rst_n         (rst_n),
    .rrq           (mcu_rrq_rom),
    .wrq           (mcu_wrq_rom),
    .req_addr_in   (mcu_addr),
    .access_window (access_window),
    .abort         (snes_revive),
    .rdy           (rdy),
    .req_addr      (req_addr),
    .rd_phase      (rd_phase),
    .wr_phase      (wr_phase),
    .wr_busy       (wr_busy),
    .rd_done       (rd_done)
  );

  // ----------------------------------------------------------------------
  // psram bus
  // ----------------------------------------------------------------------
  assign odd      = req_addr[0];
  assign rom_addr = req_addr[ADDR_W-1:1];
  assign rom_bhe  = odd;   // active low lanes
  assign rom_ble  = ~odd;
  assign rom_we   = ~wr_phase;

  // write byte only on its own lane
  assign rom_data[7:0]  = (wr_busy & odd) ? mcu_dout : 'z;
  assign rom_data[15:8] = (wr_busy & ~odd) ? mcu_dout : 'z;

  assign rom_rd = rom_data;

  // last sample of the address phase is kept
  always_ff @(posedge CLK2) begin
    if (rd_phase) rd_byte <= odd ? rom_rd.lanes.lo : rom_rd.lanes.hi;
  end

endmodule

`default_nettype wire

/* logic/sram_port.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_port #(
  parameter int unsigned RAM_CYCLE_LEN = 5
) (
  input  logic                            CLK2,
  input  logic                            rst_n,
  input  logic                            mcu_rrq_ram,
  input  logic                            mcu_wrq_ram,
  input  logic [cart_mem_pkg::ADDR_W-1:0] mcu_addr,
  input  logic [cart_mem_pkg::DATA_W-1:0] mcu_dout,
  input  logic                            access_window,
  input  logic                            snes_revive,
  input  logic [cart_mem_pkg::RAM_AW-1:0] snes_ram_addr,
  output logic                            rdy,
  output logic                            rd_done,
  output logic [cart_mem_pkg::DATA_W-1:0] rd_byte,
  output logic [cart_mem_pkg::RAM_AW-1:0] ram_addr,
  output logic                            ram_we,
  inout  wire  [cart_mem_pkg::DATA_W-1:0] ram_data
);
  import cart_mem_pkg::*;

  logic [ADDR_W-1:0] req_addr;
  logic              rd_phase;
  logic              wr_phase;
  logic              wr_busy;
  logic              mcu_active;

  mem_access_seq #(
    .CYCLE_LEN (RAM_CYCLE_LEN),
    .ADDR_W_P  (ADDR_W)
  ) u_seq (
    .CLK2          (CLK2),
    .rst_n         (rst_n),
    .rrq           (mcu_rrq_ram),
    .wrq           (mcu_wrq_ram),
    .req_addr_in   (mcu_addr),
    .access_window (access_window),
    .abort         (snes_revive),
    .rdy           (rdy),
    .req_addr      (req_addr),
    .rd_phase      (rd_phase),
    .wr_phase      (wr_phase),
    .wr_busy       (wr_busy),
    .rd_done       (rd_done)
  );

  // whole access incl. end cycle
  assign mcu_active = rd_phase | rd_done | wr_busy;

  // console mapping owns the bus otherwise
  assign ram_addr = mcu_active ? req_addr[RAM_AW-1:0] : snes_ram_addr;
  assign ram_we   = ~wr_phase;
  assign ram_data = wr_busy ? mcu_dout : 'z;

  always_ff @(posedge CLK2) begin
    if (rd_phase) rd_byte <= ram_data;
  end

endmodule

`default_nettype wire

/* logic/cart_mem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_mem_top #(
  parameter int unsigned ROM_CYCLE_LEN = 7,
  parameter int unsigned RAM_CYCLE_LEN = 5,
  parameter int unsigned DEAD_TIMEOUT  = 84000
) (
  input  logic                            CLK2,
  input  logic                            rst_n,
  input  logic [cart_mem_pkg::ADDR_W-1:0] snes_addr_in,
  input  logic                            snes_read_in,
  input  logic                            snes_romsel_in,
  input  logic                            snes_cpu_clk_in,
  inout  wire  [7:0]                      snes_data,
  output logic                            snes_databus_oe,
  output logic                            snes_databus_dir,
  output logic [cart_mem_pkg::ROM_AW-1:0] rom_addr,
  output logic                            rom_we,
  output logic                            rom_bhe,
  output logic                            rom_ble,
  inout  wire  [15:0]                     rom_data,
  output logic [cart_mem_pkg::RAM_AW-1:0] ram_addr,
  output logic                            ram_we,
  inout  wire  [7:0]                      ram_data,
  input  logic [cart_mem_pkg::ADDR_W-1:0] mcu_addr,
  input  logic [cart_mem_pkg::DATA_W-1:0] mcu_dout,
  input  logic                            mcu_rrq,
  input  logic                            mcu_wrq,
  output logic [cart_mem_pkg::DATA_W-1:0] mcu_din,
  output logic                            mcu_rdy
);
  import cart_mem_pkg::*;

  logic [ADDR_W-1:0] snes_addr;
  logic              snes_read;
  logic              snes_romsel;
  logic              cycle_start;
  logic              cycle_end;
  logic              snes_dead;
  logic              snes_revive;
  logic              rom_hit;
  logic [RAM_AW-1:0] snes_ram_addr;
  logic              access_window;
  logic              mcu_ram;
  logic              rom_rdy;
  logic              rom_rd_done;
  logic [DATA_W-1:0] rom_rd_byte;
  logic              ram_rdy;
  logic              ram_rd_done;
  logic [DATA_W-1:0] ram_rd_byte;
  logic              snes_rom_rd;

  snes_bus_sync #(.DEAD_TIMEOUT(DEAD_TIMEOUT)) u_sync (
    .CLK2(CLK2), .rst_n(rst_n),
    .snes_addr_in(snes_addr_in), .snes_read_in(snes_read_in),
    .snes_romsel_in(snes_romsel_in), .snes_cpu_clk_in(snes_cpu_clk_in),
    .snes_addr(snes_addr), .snes_read(snes_read), .snes_romsel(snes_romsel),
    .cycle_start(cycle_start), .cycle_end(cycle_end),
    .snes_dead(snes_dead), .snes_revive(snes_revive)
  );

  snes_rom_map u_map (
    .CLK2(CLK2), .rst_n(rst_n),
    .snes_addr(snes_addr), .snes_romsel(snes_romsel),
    .cycle_start(cycle_start), .cycle_end(cycle_end), .snes_dead(snes_dead),
    .rom_hit(rom_hit), .snes_ram_addr(snes_ram_addr), .access_window(access_window)
  );

  // ----------------------------------------------------------------------
  // mcu request routing
  // ----------------------------------------------------------------------
  assign mcu_ram = (mcu_addr[ADDR_W-1:ADDR_W-5] == RAM_REGION);  // else psram

  psram_port #(.ROM_CYCLE_LEN(ROM_CYCLE_LEN)) u_psram (
    .CLK2(CLK2), .rst_n(rst_n),
    .mcu_rrq_rom(mcu_rrq & ~mcu_ram), .mcu_wrq_rom(mcu_wrq & ~mcu_ram),
    .mcu_addr(mcu_addr), .mcu_dout(mcu_dout),
    .access_window(access_window), .snes_revive(snes_revive),
    .rdy(rom_rdy), .rd_done(rom_rd_done), .rd_byte(rom_rd_byte),
    .rom_addr(rom_addr), .rom_we(rom_we), .rom_bhe(rom_bhe), .rom_ble(rom_ble),
    .rom_data(rom_data)
  );

  sram_port #(.RAM_CYCLE_LEN(RAM_CYCLE_LEN)) u_sram (
    .CLK2(CLK2), .rst_n(rst_n),
    .mcu_rrq_ram(mcu_rrq & mcu_ram), .mcu_wrq_ram(mcu_wrq & mcu_ram),
    .mcu_addr(mcu_addr), .mcu_dout(mcu_dout),
    .access_window(access_window), .snes_revive(snes_revive),
    .snes_ram_addr(snes_ram_addr),
    .rdy(ram_rdy), .rd_done(ram_rd_done), .rd_byte(ram_rd_byte),
    .ram_addr(ram_addr), .ram_we(ram_we), .ram_data(ram_data)
  );

  // valid from the cycle rdy rises
  always_ff @(posedge CLK2) begin
    if (rom_rd_done) mcu_din <= rom_rd_byte;
    else if (ram_rd_done) mcu_din <= ram_rd_byte;
  end

  assign mcu_rdy = rom_rdy & ram_rdy;

  // ----------------------------------------------------------------------
  // console data bus
  // ----------------------------------------------------------------------
  assign snes_rom_rd      = rom_hit & ~snes_read;
  assign snes_data        = snes_rom_rd ? ram_data : 'z;
  assign snes_databus_dir = snes_rom_rd;   // 1: cart drives console
  assign snes_databus_oe  = ~snes_rom_rd;  // transceiver enable, active low

endmodule

`default_nettype wire

/* verification/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS = 10
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(PERIOD_NS / 2.0) clk = ~clk;  // 50% duty

endmodule

`default_nettype wire

/* verification/cart_mem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_mem_tb;
  import cart_mem_pkg::*;

  localparam int DEAD_TIMEOUT = 200;
  localparam int CON_HALF     = 16;  // console clock half period in CLK2 cycles
  localparam int N_PAIRS      = 16;
  localparam int N_MIX        = 12;
  localparam int N_CON        = 24;
  localparam int DEAD_GAP     = DEAD_TIMEOUT + 60;
  localparam int N_ACCESS     = 4 * N_PAIRS + N_MIX + 2;
  localparam int CYCLE_LIMIT  = 40 * N_ACCESS + 2 * CON_HALF * (N_CON + 4) + DEAD_GAP + 300;

  logic              CLK2;
  logic              rst_n;
  logic [ADDR_W-1:0] snes_addr_in;
  logic              snes_read_in;
  logic              snes_romsel_in;
  logic              snes_cpu_clk_in;
  wire  [7:0]        snes_data;
  logic              snes_databus_oe;
  logic              snes_databus_dir;
  logic [ROM_AW-1:0] rom_addr;
  logic              rom_we;
  logic              rom_bhe;
  logic              rom_ble;
  wire  [15:0]       rom_data;
  logic [RAM_AW-1:0] ram_addr;
  logic              ram_we;
  wire  [7:0]        ram_data;
  logic [ADDR_W-1:0] mcu_addr;
  logic [DATA_W-1:0] mcu_dout;
  logic              mcu_rrq;
  logic              mcu_wrq;
  logic [DATA_W-1:0] mcu_din;
  logic              mcu_rdy;

  logic [DATA_W-1:0] sram_mem [0:(1<<RAM_AW)-1];
  psram_data_t       psram_mem [int unsigned];  // keyed by word address
  psram_data_t       psram_q;
  logic [DATA_W-1:0] rom_shadow [int unsigned];  // keyed by byte address
  logic [DATA_W-1:0] ram_shadow [int unsigned];
  logic [ADDR_W-1:0] rom_list [$];
  logic [ADDR_W-1:0] ram_list [$];
  logic [ADDR_W-1:0] con_addr [$];
  int                cycle_cnt = 0;

  tb_clk_gen #(.PERIOD_NS(10)) u_clk (.clk(CLK2));

  cart_mem_top #(.DEAD_TIMEOUT(DEAD_TIMEOUT)) dut0 (
    .CLK2(CLK2), .rst_n(rst_n),
    .snes_addr_in(snes_addr_in), .snes_read_in(snes_read_in),
    .snes_romsel_in(snes_romsel_in), .snes_cpu_clk_in(snes_cpu_clk_in),
    .snes_data(snes_data), .snes_databus_oe(snes_databus_oe),
    .snes_databus_dir(snes_databus_dir),
    .rom_addr(rom_addr), .rom_we(rom_we), .rom_bhe(rom_bhe), .rom_ble(rom_ble),
    .rom_data(rom_data),
    .ram_addr(ram_addr), .ram_we(ram_we), .ram_data(ram_data),
    .mcu_addr(mcu_addr), .mcu_dout(mcu_dout), .mcu_rrq(mcu_rrq), .mcu_wrq(mcu_wrq),
    .mcu_din(mcu_din), .mcu_rdy(mcu_rdy)
  );

  // ----------------------------------------------------------------------
  // error handling and checks
  // ----------------------------------------------------------------------
  task automatic stop_on_error();
    $display("sim failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_mcu_byte(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                                input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_snes_byte(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                                 input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_rom_addr(input logic [ROM_AW-1:0] got, input logic [ROM_AW-1:0] exp,
                                input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  task automatic compare_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  always @(posedge CLK2) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == CYCLE_LIMIT) begin
      $display("timeout: run went past %0d cycles without finishing", CYCLE_LIMIT);
      stop_on_error();
    end
  end

  // ----------------------------------------------------------------------
  // memory models
  // ----------------------------------------------------------------------
  // sram preload pattern mixes every address bit
  function automatic logic [DATA_W-1:0] fill_byte(input logic [RAM_AW-1:0] a);
    logic [31:0] x;
    x = 32'(a);
    return DATA_W'(x ^ (x >> 7) ^ (x >> 13) ^ 32'h5a);
  endfunction

  function automatic logic [DATA_W-1:0] ram_expect(input logic [RAM_AW-1:0] a);
    if (ram_shadow.exists(a)) return ram_shadow[a];
    return fill_byte(a);
  endfunction

  always @(posedge CLK2) begin : psram_model
    psram_data_t w;
    w = '0;
    if (!$isunknown(rom_addr) && psram_mem.exists(rom_addr)) w = psram_mem[rom_addr];
    if (rom_we === 1'b0) begin
      check_rom_addr(rom_addr, ROM_AW'(mcu_addr >> 1), "rom_addr");  // byte address halved
      compare_flag(rom_bhe, mcu_addr[0], "rom_bhe");  // odd byte uses low lane
      compare_flag(rom_ble, ~mcu_addr[0], "rom_ble");
      if (!rom_ble) w.lanes.lo = rom_data[7:0];
      if (!rom_bhe) w.lanes.hi = rom_data[15:8];
      psram_mem[rom_addr] = w;
    end
    psram_q <= w;
  end

  assign rom_data = rom_we ? psram_q.word : 'z;

  always @(posedge CLK2) begin
    if (ram_we === 1'b0) sram_mem[ram_addr] <= ram_data;
  end

  assign ram_data = ram_we ? sram_mem[ram_addr] : 'z;

  // ----------------------------------------------------------------------
  // mcu and console drivers
  // ----------------------------------------------------------------------
  function automatic logic in_sram(input logic [ADDR_W-1:0] a);
    return a[ADDR_W-1 -: 5] == RAM_REGION;
  endfunction

  function automatic logic [ADDR_W-1:0] random_psram_addr();
    logic [ADDR_W-1:0] a;
    do begin
      a = ADDR_W'($urandom);
    end while (in_sram(a));
    return a;
  endfunction

  function automatic logic [ADDR_W-1:0] region_sram_addr();
    return {RAM_REGION, RAM_AW'($urandom)};
  endfunction

  task automatic wait_ready();
    @(negedge CLK2);
    compare_flag(mcu_rdy, 1'b0, "mcu_rdy after request");
    while (mcu_rdy !== 1'b1) @(negedge CLK2);
  endtask

  task automatic write_byte(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    @(posedge CLK2);
    mcu_addr <= addr;
    mcu_dout <= data;
    mcu_wrq  <= 1'b1;
    @(posedge CLK2);
    mcu_wrq <= 1'b0;
    wait_ready();
    if (in_sram(addr)) ram_shadow[addr[RAM_AW-1:0]] = data;
    else rom_shadow[addr] = data;
  endtask

  task automatic read_byte(input logic [ADDR_W-1:0] addr);
    logic [DATA_W-1:0] exp;
    @(posedge CLK2);
    mcu_addr <= addr;
    mcu_rrq  <= 1'b1;
    @(posedge CLK2);
    mcu_rrq <= 1'b0;
    wait_ready();
    if (in_sram(addr)) exp = ram_expect(addr[RAM_AW-1:0]);
    else exp = rom_shadow[addr];
    check_mcu_byte(mcu_din, exp, $sformatf("mcu read %h", addr));
  endtask

  // one console rom read with low phase then high phase
  task automatic console_cycle(input logic [ADDR_W-1:0] addr);
    logic [RAM_AW-1:0] mapped;
    mapped = RAM_AW'(32'(addr[19:16]) * 32'h8000 + 32'(addr[14:0]));  // 32KB per bank
    @(posedge CLK2);
    snes_cpu_clk_in <= 1'b0;
    snes_addr_in    <= addr;
    snes_romsel_in  <= 1'b0;
    snes_read_in    <= 1'b0;
    repeat (CON_HALF) @(posedge CLK2);
    snes_cpu_clk_in <= 1'b1;
    repeat (CON_HALF - 1) @(posedge CLK2);
    @(negedge CLK2);
    check_snes_byte(snes_data, ram_expect(mapped), $sformatf("console read %h", addr));
    compare_flag(snes_databus_dir, 1'b1, "snes_databus_dir");
    compare_flag(snes_databus_oe, 1'b0, "snes_databus_oe");
  endtask

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------
  initial begin
    int                seed;
    logic [ADDR_W-1:0] a;
    rst_n           = 1'b0;
    snes_addr_in    = '0;
    snes_read_in    = 1'b1;
    snes_romsel_in  = 1'b1;
    snes_cpu_clk_in = 1'b0;  // console starts dead
    mcu_addr        = '0;
    mcu_dout        = '0;
    mcu_rrq         = 1'b0;
    mcu_wrq         = 1'b0;
    seed            = 32'h449f3382;
    void'($urandom(seed));
    for (int i = 0; i < (1 << RAM_AW); i++) sram_mem[i] = fill_byte(RAM_AW'(i));
    for (int i = 0; i < N_CON + 3; i++) con_addr.push_back(ADDR_W'($urandom));

    repeat (10) @(posedge CLK2);
    rst_n <= 1'b1;
    @(negedge CLK2);
    compare_flag(mcu_rdy, 1'b1, "mcu_rdy after reset");
    compare_flag(rom_we, 1'b1, "rom_we after reset");
    compare_flag(ram_we, 1'b1, "ram_we after reset");
    compare_flag(snes_databus_oe, 1'b1, "snes_databus_oe after reset");
    compare_flag(snes_databus_dir, 1'b0, "snes_databus_dir after reset");

    // psram with the console dead covers both lanes of each word
    for (int i = 0; i < N_PAIRS; i++) begin
      if (i % 2 == 0) a = random_psram_addr();
      else a = a ^ ADDR_W'(1);
      rom_list.push_back(a);
      write_byte(a, DATA_W'($urandom));
    end
    foreach (rom_list[i]) read_byte(rom_list[i]);

    // same pattern in the sram region
    for (int i = 0; i < N_PAIRS; i++) begin
      a = region_sram_addr();
      ram_list.push_back(a);
      write_byte(a, DATA_W'($urandom));
    end
    foreach (ram_list[i]) read_byte(ram_list[i]);

    // mcu traffic squeezed into free slots of a running console
    fork
      for (int k = 0; k < N_CON; k++) console_cycle(con_addr[k]);
      for (int i = 0; i < N_MIX; i++) begin
        case ($urandom_range(3, 0))
          0: begin
            a = random_psram_addr();
            rom_list.push_back(a);
            write_byte(a, DATA_W'($urandom));
          end
          1: read_byte(rom_list[$urandom_range(rom_list.size() - 1, 0)]);
          2: write_byte(region_sram_addr(), DATA_W'($urandom));
          default: read_byte(region_sram_addr());
        endcase
      end
    join

    // console dies and wakes in the middle of a read
    @(posedge CLK2);
    snes_cpu_clk_in <= 1'b0;
    repeat (DEAD_GAP) @(posedge CLK2);
    a = random_psram_addr();
    write_byte(a, DATA_W'($urandom));
    fork
      read_byte(a);
      begin
        repeat (3) @(posedge CLK2);
        snes_cpu_clk_in <= 1'b1;  // revive lands in the address phase
        repeat (CON_HALF) @(posedge CLK2);
        for (int k = N_CON; k < N_CON + 3; k++) console_cycle(con_addr[k]);
      end
    join

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
logic/cart_mem_pkg.sv
logic/snes_bus_sync.sv
logic/snes_rom_map.sv
logic/mem_access_seq.sv
logic/psram_port.sv
logic/sram_port.sv
logic/cart_mem_top.sv
verification/tb_clk_gen.sv
verification/cart_mem_tb.sv
